// ==== rtl/hbmc_consts.svh ====
// Width, memory size, FIFO depth and AXI code macros included by the RTL and the testbench
`ifndef HBMC_CONSTS_SVH
`define HBMC_CONSTS_SVH

// AXI side
`define HBMC_DATA_W      32
`define HBMC_ADDR_W      32
`define HBMC_ID_W        4

// memory side
`define HBMC_WORD_W      16
`define HBMC_MEM_BYTES   2048
`define HBMC_MEM_AW      10     // word address bits for HBMC_MEM_BYTES

// one full 16-beat burst per FIFO
`define HBMC_FIFO_DEPTH  16

`define HBMC_BURST_WRAP  2'b10
`define HBMC_RESP_OKAY   2'b00

`endif

// ==== rtl/hbmc_pkg.sv ====
// Payload structs passed between the arbiter, FIFOs, burst engine and word RAM
`include "hbmc_consts.svh"

package hbmc_pkg;

    // one memory command in 16-bit words
    typedef struct packed {
        logic [`HBMC_MEM_AW-1:0] addr;          // first word address
        logic [15:0]             word_cnt;      // (len+1)*2
        logic                    wr_not_rd;
        logic                    wrap_not_incr;
    } hbmc_cmd_t;

    // write beat as taken from the W channel
    typedef struct packed {
        logic [`HBMC_DATA_W-1:0]   data;
        logic [`HBMC_DATA_W/8-1:0] strb;
    } hbmc_wbeat_t;

    // read beat heading for the R channel
    typedef struct packed {
        logic [`HBMC_DATA_W-1:0] data;
        logic                    last;
    } hbmc_rbeat_t;

    // single word access to the memory
    typedef struct packed {
        logic [`HBMC_MEM_AW-1:0]   addr;
        logic [`HBMC_WORD_W-1:0]   wdata;
        logic [`HBMC_WORD_W/8-1:0] strb;
        logic                      we;
    } hbmc_ram_req_t;

endpackage

// ==== rtl/hbmc_stream_fifo.sv ====
// Synchronous valid/ready FIFO whose payload type is set per instance
`timescale 1ns/100ps

module hbmc_stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 16
) (
    input  logic     s_axi_aclk,
    input  logic     s_axi_aresetn,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int ptr_w = $clog2(depth);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;    // entries held
    logic             push;
    logic             pop;

    function automatic logic [ptr_w-1:0] bump(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready  = (count != (ptr_w + 1)'(depth));
    assign out_valid = (count != '0);
    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;
    assign out_data  = mem[rd_ptr];

    always_ff @(posedge s_axi_aclk) begin
        if (push) mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= bump(wr_ptr);
            if (pop) rd_ptr <= bump(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // idle or both at once
            endcase
        end
    end

endmodule

// ==== rtl/hbmc_axi_arbiter.sv ====
// AXI address arbiter that builds word commands and runs the write response
`timescale 1ns/100ps
`include "hbmc_consts.svh"

module hbmc_axi_arbiter (
    input  logic                    s_axi_aclk,
    input  logic                    s_axi_aresetn,
    input  logic [`HBMC_ID_W-1:0]   s_axi_awid,
    input  logic [`HBMC_ADDR_W-1:0] s_axi_awaddr,
    input  logic [7:0]              s_axi_awlen,
    input  logic [2:0]              s_axi_awsize,
    input  logic [1:0]              s_axi_awburst,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    input  logic [`HBMC_ID_W-1:0]   s_axi_arid,
    input  logic [`HBMC_ADDR_W-1:0] s_axi_araddr,
    input  logic [7:0]              s_axi_arlen,
    input  logic [2:0]              s_axi_arsize,
    input  logic [1:0]              s_axi_arburst,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    input  logic                    w_last_seen,
    input  logic                    r_last_done,
    output logic [`HBMC_ID_W-1:0]   s_axi_bid,
    output logic [1:0]              s_axi_bresp,
    output logic                    s_axi_bvalid,
    input  logic                    s_axi_bready,
    output logic [`HBMC_ID_W-1:0]   s_axi_rid,
    output logic                    cmd_valid,
    output hbmc_pkg::hbmc_cmd_t     cmd,
    input  logic                    cmd_ready,
    input  logic                    eng_wr_done
);

    // keeps the byte offset inside memory, drops the offset inside a beat
    localparam logic [`HBMC_ADDR_W-1:0] addr_mask =
        (`HBMC_MEM_BYTES - 1) & ~(`HBMC_DATA_W / 8 - 1);

    typedef enum logic [1:0] {ST_IDLE, ST_SELECT, ST_ISSUE, ST_WAIT} state_t;

    state_t                state;
    logic [4:0]            w_bursts;    // bursts fully in the write FIFO, address pending
    logic                  rd_busy;     // read accepted, rlast not yet seen
    logic [`HBMC_ID_W-1:0] id_q;
    logic                  wr_cond;
    logic                  rd_cond;
    logic                  pick_wr;

    function automatic hbmc_pkg::hbmc_cmd_t build_cmd(
        input logic [`HBMC_ADDR_W-1:0] addr,
        input logic [7:0]              len,
        input logic [2:0]              size,
        input logic [1:0]              burst,
        input logic                    wr
    );
        hbmc_pkg::hbmc_cmd_t     c;
        logic [`HBMC_ADDR_W-1:0] byte_addr;
        byte_addr       = addr & addr_mask;
        c.addr          = byte_addr[`HBMC_MEM_AW:1];            // bytes to words
        c.word_cnt      = (16'(len) + 16'd1) << (size - 3'd1);  // two words per beat
        c.wr_not_rd     = wr;
        c.wrap_not_incr = (burst == `HBMC_BURST_WRAP);
        return c;
    endfunction

    assign wr_cond = s_axi_awvalid & (w_bursts != '0);
    assign rd_cond = s_axi_arvalid & ~rd_busy;
    // on a tie take the opposite of the last command
    assign pick_wr = wr_cond & (~rd_cond | ~cmd.wr_not_rd);

    assign s_axi_bid   = id_q;
    assign s_axi_rid   = id_q;
    assign s_axi_bresp = `HBMC_RESP_OKAY;

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            w_bursts <= '0;
            rd_busy  <= 1'b0;
        end else begin
            case ({w_last_seen, s_axi_awvalid & s_axi_awready})
                2'b10:   w_bursts <= w_bursts + 1'b1;
                2'b01:   w_bursts <= w_bursts - 1'b1;
                default: w_bursts <= w_bursts;
            endcase
            if (s_axi_arvalid && s_axi_arready) rd_busy <= 1'b1;
            else if (r_last_done) rd_busy <= 1'b0;
        end
    end

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            state         <= ST_IDLE;
            s_axi_awready <= 1'b0;
            s_axi_arready <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            cmd_valid     <= 1'b0;
            cmd           <= '0;
            id_q          <= '0;
        end else begin
            if (state == ST_WAIT && cmd.wr_not_rd && eng_wr_done) s_axi_bvalid <= 1'b1;
            else if (s_axi_bready) s_axi_bvalid <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (wr_cond || rd_cond) state <= ST_SELECT;
                end
                ST_SELECT: begin
                    if (pick_wr) begin
                        s_axi_awready <= 1'b1;
                        id_q          <= s_axi_awid;
                        cmd           <= build_cmd(s_axi_awaddr, s_axi_awlen, s_axi_awsize,
                                                   s_axi_awburst, 1'b1);
                    end else begin
                        s_axi_arready <= 1'b1;
                        id_q          <= s_axi_arid;
                        cmd           <= build_cmd(s_axi_araddr, s_axi_arlen, s_axi_arsize,
                                                   s_axi_arburst, 1'b0);
                    end
                    state <= ST_ISSUE;
                end
                ST_ISSUE: begin
                    s_axi_awready <= 1'b0;  // single-cycle ready pulse
                    s_axi_arready <= 1'b0;
                    if (!cmd_valid) begin
                        cmd_valid <= 1'b1;
                    end else if (cmd_ready) begin
                        cmd_valid <= 1'b0;
                        state     <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (cmd.wr_not_rd ? (s_axi_bvalid && s_axi_bready) : r_last_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/hbmc_burst_engine.sv ====
// Burst engine that turns one command into word accesses and converts beats to and from words
`timescale 1ns/100ps
`include "hbmc_consts.svh"

module hbmc_burst_engine (
    input  logic                      s_axi_aclk,
    input  logic                      s_axi_aresetn,
    input  logic                      cmd_valid,
    input  hbmc_pkg::hbmc_cmd_t       cmd,
    output logic                      cmd_ready,
    input  logic                      wbeat_valid,
    input  hbmc_pkg::hbmc_wbeat_t     wbeat,
    output logic                      wbeat_ready,
    output logic                      ram_valid,
    output hbmc_pkg::hbmc_ram_req_t   ram_req,
    input  logic [`HBMC_WORD_W-1:0]   rd_word,
    output logic                      rbeat_valid,
    output hbmc_pkg::hbmc_rbeat_t     rbeat,
    input  logic                      rbeat_ready,
    output logic                      eng_wr_done
);

    typedef enum logic [1:0] {ST_IDLE, ST_WRITE, ST_READ} state_t;

    state_t                   state;
    logic [15:0]              words_left;
    logic [`HBMC_MEM_AW-1:0]  addr;
    logic [`HBMC_MEM_AW-1:0]  wrap_mask;  // all ones for INCR
    logic [`HBMC_MEM_AW-1:0]  next_addr;
    logic                     word_go;    // a word access leaves this cycle
    logic                     rd_idle;
    logic                     ret_v;      // rd_word valid this cycle
    logic                     ret_hi;
    logic [`HBMC_WORD_W-1:0]  lo_q;

    // odd word address is always the upper half of a beat
    assign next_addr = (addr & ~wrap_mask) | ((addr + 1'b1) & wrap_mask);
    assign rd_idle   = ~ram_valid & ~ret_v;
    assign word_go   = (state == ST_WRITE && wbeat_valid) ||
                       (state == ST_READ && (addr[0] || (rd_idle && rbeat_ready)));

    assign cmd_ready   = (state == ST_IDLE);
    assign wbeat_ready = (state == ST_WRITE) && addr[0];  // pop with the high word
    assign rbeat_valid = ret_v & ret_hi;
    assign rbeat.data  = {rd_word, lo_q};
    assign rbeat.last  = (words_left == '0);

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            state       <= ST_IDLE;
            words_left  <= '0;
            ram_valid   <= 1'b0;
            eng_wr_done <= 1'b0;
            ret_v       <= 1'b0;
        end else begin
            ram_valid   <= word_go;
            eng_wr_done <= 1'b0;
            ret_v       <= ram_valid & ~ram_req.we;  // RAM answers one cycle later
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        words_left <= cmd.word_cnt;
                        state      <= cmd.wr_not_rd ? ST_WRITE : ST_READ;
                    end
                end
                ST_WRITE, ST_READ: begin
                    if (word_go) begin
                        words_left <= words_left - 1'b1;
                        if (words_left == 16'd1) begin
                            state       <= ST_IDLE;
                            eng_wr_done <= (state == ST_WRITE);
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        ret_hi <= ram_req.addr[0];
        if (ret_v && !ret_hi) lo_q <= rd_word;  // hold low word until its pair
        if (cmd_valid && cmd_ready) begin
            addr      <= cmd.addr;
            wrap_mask <= cmd.wrap_not_incr ? cmd.word_cnt[`HBMC_MEM_AW-1:0] - 1'b1 : '1;
        end else if (word_go) begin
            addr <= next_addr;
        end
        if (word_go) begin
            ram_req.addr  <= addr;
            ram_req.wdata <= addr[0] ? wbeat.data[31:16] : wbeat.data[15:0];
            ram_req.strb  <= addr[0] ? wbeat.strb[3:2] : wbeat.strb[1:0];
            ram_req.we    <= (state == ST_WRITE);
        end
    end

endmodule

// ==== rtl/hbmc_word_ram.sv ====
// On-chip 16-bit word memory with byte strobes used in place of the HyperBus device
`timescale 1ns/100ps
`include "hbmc_consts.svh"

module hbmc_word_ram (
    input  logic                    s_axi_aclk,
    input  logic                    ram_valid,
    input  hbmc_pkg::hbmc_ram_req_t ram_req,
    output logic [`HBMC_WORD_W-1:0] rd_word
);

    localparam int words = `HBMC_MEM_BYTES / 2;

    logic [`HBMC_WORD_W-1:0] mem [words];

    always_ff @(posedge s_axi_aclk) begin
        if (ram_valid) begin
            if (ram_req.we) begin
                if (ram_req.strb[0]) mem[ram_req.addr][7:0]  <= ram_req.wdata[7:0];
                if (ram_req.strb[1]) mem[ram_req.addr][15:8] <= ram_req.wdata[15:8];
            end else begin
                rd_word <= mem[ram_req.addr];  // registered read
            end
        end
    end

endmodule

// ==== rtl/hbmc_axi_top.sv ====
// AXI4 slave top level that connects arbiter, data FIFOs, burst engine and word RAM
`timescale 1ns/100ps
`include "hbmc_consts.svh"

module hbmc_axi_top (
    input  logic                      s_axi_aclk,
    input  logic                      s_axi_aresetn,
    input  logic [`HBMC_ID_W-1:0]     s_axi_awid,
    input  logic [`HBMC_ADDR_W-1:0]   s_axi_awaddr,
    input  logic [7:0]                s_axi_awlen,
    input  logic [2:0]                s_axi_awsize,
    input  logic [1:0]                s_axi_awburst,
    input  logic                      s_axi_awvalid,
    output logic                      s_axi_awready,
    input  logic [`HBMC_DATA_W-1:0]   s_axi_wdata,
    input  logic [`HBMC_DATA_W/8-1:0] s_axi_wstrb,
    input  logic                      s_axi_wlast,
    input  logic                      s_axi_wvalid,
    output logic                      s_axi_wready,
    output logic [`HBMC_ID_W-1:0]     s_axi_bid,
    output logic [1:0]                s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  logic                      s_axi_bready,
    input  logic [`HBMC_ID_W-1:0]     s_axi_arid,
    input  logic [`HBMC_ADDR_W-1:0]   s_axi_araddr,
    input  logic [7:0]                s_axi_arlen,
    input  logic [2:0]                s_axi_arsize,
    input  logic [1:0]                s_axi_arburst,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,
    output logic [`HBMC_ID_W-1:0]     s_axi_rid,
    output logic [`HBMC_DATA_W-1:0]   s_axi_rdata,
    output logic [1:0]                s_axi_rresp,
    output logic                      s_axi_rlast,
    output logic                      s_axi_rvalid,
    input  logic                      s_axi_rready
);

    hbmc_pkg::hbmc_cmd_t     cmd;
    hbmc_pkg::hbmc_wbeat_t   wfifo_in;
    hbmc_pkg::hbmc_wbeat_t   wbeat;
    hbmc_pkg::hbmc_rbeat_t   rbeat;
    hbmc_pkg::hbmc_rbeat_t   rfifo_out;
    hbmc_pkg::hbmc_ram_req_t ram_req;
    logic                    cmd_valid;
    logic                    cmd_ready;
    logic                    wbeat_valid;
    logic                    wbeat_ready;
    logic                    rbeat_valid;
    logic                    rbeat_ready;
    logic                    ram_valid;
    logic [`HBMC_WORD_W-1:0] rd_word;
    logic                    eng_wr_done;
    logic                    w_last_seen;
    logic                    r_last_done;

    assign wfifo_in    = '{data: s_axi_wdata, strb: s_axi_wstrb};
    assign w_last_seen = s_axi_wvalid & s_axi_wready & s_axi_wlast;
    assign r_last_done = s_axi_rvalid & s_axi_rready & s_axi_rlast;
    assign s_axi_rdata = rfifo_out.data;
    assign s_axi_rlast = rfifo_out.last;
    assign s_axi_rresp = `HBMC_RESP_OKAY;

    hbmc_axi_arbiter i_arbiter (.*);

    hbmc_stream_fifo #(
        .payload_t (hbmc_pkg::hbmc_wbeat_t),
        .depth     (`HBMC_FIFO_DEPTH)
    ) i_wfifo (
        .s_axi_aclk, .s_axi_aresetn,
        .in_valid  (s_axi_wvalid),
        .in_ready  (s_axi_wready),
        .in_data   (wfifo_in),
        .out_valid (wbeat_valid),
        .out_ready (wbeat_ready),
        .out_data  (wbeat)
    );

    hbmc_stream_fifo #(
        .payload_t (hbmc_pkg::hbmc_rbeat_t),
        .depth     (`HBMC_FIFO_DEPTH)
    ) i_rfifo (
        .s_axi_aclk, .s_axi_aresetn,
        .in_valid  (rbeat_valid),
        .in_ready  (rbeat_ready),
        .in_data   (rbeat),
        .out_valid (s_axi_rvalid),
        .out_ready (s_axi_rready),
        .out_data  (rfifo_out)
    );

    hbmc_burst_engine i_engine (.*);

    hbmc_word_ram i_ram (.*);

endmodule

// ==== tb/hbmc_assertions.sv ====
// Protocol assertions bound to the AXI top level for use in the testbench
`timescale 1ns/100ps
`include "hbmc_consts.svh"

module hbmc_assertions (
    input logic                    s_axi_aclk,
    input logic                    s_axi_aresetn,
    input logic                    s_axi_awvalid,
    input logic                    s_axi_awready,
    input logic                    s_axi_arready,
    input logic                    s_axi_wvalid,
    input logic                    s_axi_wready,
    input logic                    s_axi_wlast,
    input logic                    s_axi_bvalid,
    input logic                    s_axi_bready,
    input logic                    s_axi_rvalid,
    input logic                    s_axi_rready,
    input logic [`HBMC_DATA_W-1:0] s_axi_rdata
);

    logic [4:0] wlast_pend;    // wlast handshakes not yet matched by an address

    always_ff @(posedge s_axi_aclk or negedge s_axi_aresetn) begin
        if (!s_axi_aresetn) begin
            wlast_pend <= '0;
        end else begin
            wlast_pend <= wlast_pend + 5'(s_axi_wvalid & s_axi_wready & s_axi_wlast)
                          - 5'(s_axi_awvalid & s_axi_awready);
        end
    end

    a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else $error("bvalid dropped before bready");

    a_r_stable: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
        else $error("read data changed while stalled");

    a_ready_excl: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        !(s_axi_awready && s_axi_arready))
        else $error("awready and arready high together");

    a_aw_after_wlast: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        $rose(s_axi_awready) |-> wlast_pend != '0)
        else $error("awready without a finished write burst");

endmodule

bind hbmc_axi_top hbmc_assertions i_assertions (.*);

// ==== tb/hbmc_tb.sv ====
// Testbench for the AXI4 slave front end: random bursts checked against a byte model of the memory
`timescale 1ns/100ps
`include "hbmc_consts.svh"

module hbmc_tb;

    localparam int mem_bytes = `HBMC_MEM_BYTES;
    localparam int n_init    = mem_bytes / 64;      // 16-beat bursts that fill the memory
    localparam int n_incr    = 24;
    localparam int n_wrap    = 8;
    localparam int n_pair    = 6;
    localparam int n_tests   = n_init + 2 * (n_incr + n_wrap + n_pair);
    localparam logic [1:0] burst_incr = 2'b01;

    logic                      s_axi_aclk = 1'b0;
    logic                      s_axi_aresetn;
    logic [`HBMC_ID_W-1:0]     s_axi_awid;
    logic [`HBMC_ADDR_W-1:0]   s_axi_awaddr;
    logic [7:0]                s_axi_awlen;
    logic [2:0]                s_axi_awsize;
    logic [1:0]                s_axi_awburst;
    logic                      s_axi_awvalid;
    logic                      s_axi_awready;
    logic [`HBMC_DATA_W-1:0]   s_axi_wdata;
    logic [`HBMC_DATA_W/8-1:0] s_axi_wstrb;
    logic                      s_axi_wlast;
    logic                      s_axi_wvalid;
    logic                      s_axi_wready;
    logic [`HBMC_ID_W-1:0]     s_axi_bid;
    logic [1:0]                s_axi_bresp;
    logic                      s_axi_bvalid;
    logic                      s_axi_bready;
    logic [`HBMC_ID_W-1:0]     s_axi_arid;
    logic [`HBMC_ADDR_W-1:0]   s_axi_araddr;
    logic [7:0]                s_axi_arlen;
    logic [2:0]                s_axi_arsize;
    logic [1:0]                s_axi_arburst;
    logic                      s_axi_arvalid;
    logic                      s_axi_arready;
    logic [`HBMC_ID_W-1:0]     s_axi_rid;
    logic [`HBMC_DATA_W-1:0]   s_axi_rdata;
    logic [1:0]                s_axi_rresp;
    logic                      s_axi_rlast;
    logic                      s_axi_rvalid;
    logic                      s_axi_rready;

    integer     seed = 32'h6a5835f5;
    logic [7:0] model [mem_bytes];      // reference copy of the memory

    hbmc_axi_top i_hbmc_axi_top (.*);

    always #10 s_axi_aclk = ~s_axi_aclk;

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // byte address of beat i after masking, alignment and wrapping
    function automatic int beat_addr(input logic [31:0] addr, input int len,
                                     input logic [1:0] burst, input int i);
        int base;
        int blk;
        base = addr & (mem_bytes - 4);
        blk  = (len + 1) * 4;
        if (burst == `HBMC_BURST_WRAP) return (base & ~(blk - 1)) | ((base + 4 * i) & (blk - 1));
        return (base + 4 * i) % mem_bytes;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic write_burst(input logic [3:0] id, input logic [31:0] addr, input int len,
                               input logic [1:0] burst, input bit full_strb);
        logic [31:0] data [16];
        logic [3:0]  strb [16];
        int          a;
        for (int i = 0; i <= len; i++) begin
            data[i] = $random(seed);
            strb[i] = full_strb ? 4'hf : 4'(rand_below(16));
            a = beat_addr(addr, len, burst, i);
            for (int b = 0; b < 4; b++) begin
                if (strb[i][b]) model[a + b] = data[i][8*b +: 8];
            end
        end
        fork
            begin
                for (int i = 0; i <= len; i++) begin
                    while (rand_below(4) == 0) begin   // random gap before a beat
                        s_axi_wvalid = 1'b0;
                        @(negedge s_axi_aclk);
                    end
                    s_axi_wvalid = 1'b1;
                    s_axi_wdata  = data[i];
                    s_axi_wstrb  = strb[i];
                    s_axi_wlast  = (i == len);
                    while (!s_axi_wready) @(negedge s_axi_aclk);
                    @(negedge s_axi_aclk);
                end
                s_axi_wvalid = 1'b0;
                s_axi_wlast  = 1'b0;
            end
            begin
                s_axi_awvalid = 1'b1;
                s_axi_awid    = id;
                s_axi_awaddr  = addr;
                s_axi_awlen   = 8'(len);
                s_axi_awburst = burst;
                while (!s_axi_awready) @(negedge s_axi_aclk);
                @(negedge s_axi_aclk);
                s_axi_awvalid = 1'b0;
            end
        join
        forever begin
            s_axi_bready = rand_below(2) != 0;
            if (s_axi_bvalid && s_axi_bready) break;
            @(negedge s_axi_aclk);
        end
        check("s_axi_bid", 32'(id), 32'(s_axi_bid));
        check("s_axi_bresp", `HBMC_RESP_OKAY, 32'(s_axi_bresp));
        @(negedge s_axi_aclk);
        s_axi_bready = 1'b0;
    endtask

    task automatic read_burst(input logic [3:0] id, input logic [31:0] addr, input int len,
                              input logic [1:0] burst);
        logic [31:0] exp [16];
        int          a;
        for (int i = 0; i <= len; i++) begin
            a = beat_addr(addr, len, burst, i);
            exp[i] = {model[a + 3], model[a + 2], model[a + 1], model[a]};
        end
        fork
            begin
                s_axi_arvalid = 1'b1;
                s_axi_arid    = id;
                s_axi_araddr  = addr;
                s_axi_arlen   = 8'(len);
                s_axi_arburst = burst;
                while (!s_axi_arready) @(negedge s_axi_aclk);
                @(negedge s_axi_aclk);
                s_axi_arvalid = 1'b0;
            end
            begin
                for (int k = 0; k <= len; k++) begin
                    forever begin
                        s_axi_rready = rand_below(4) != 0;
                        if (s_axi_rvalid && s_axi_rready) break;
                        @(negedge s_axi_aclk);
                    end
                    check("s_axi_rid", 32'(id), 32'(s_axi_rid));
                    check("s_axi_rresp", `HBMC_RESP_OKAY, 32'(s_axi_rresp));
                    check("s_axi_rdata", exp[k], s_axi_rdata);
                    check("s_axi_rlast", 32'(k == len), 32'(s_axi_rlast));
                    @(negedge s_axi_aclk);
                end
                s_axi_rready = 1'b0;
                check("s_axi_rvalid after rlast", 32'd0, 32'(s_axi_rvalid));   // no extra beat
            end
        join
    endtask

    initial begin
        repeat (n_tests * 200) @(posedge s_axi_aclk);
        $display("Watchdog expired: the DUT stopped answering a handshake");
        $display("TEST FAILED");
        $fatal(1, "simulation timed out");
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] raddr;
        int          len;
        s_axi_aresetn = 1'b0;
        s_axi_awid    = '0;
        s_axi_awaddr  = '0;
        s_axi_awlen   = '0;
        s_axi_awsize  = 3'd2;   // full 32-bit beats only
        s_axi_awburst = burst_incr;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = '0;
        s_axi_wlast   = 1'b0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_arid    = '0;
        s_axi_araddr  = '0;
        s_axi_arlen   = '0;
        s_axi_arsize  = 3'd2;
        s_axi_arburst = burst_incr;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        repeat (3) @(posedge s_axi_aclk);
        @(negedge s_axi_aclk);
        s_axi_aresetn = 1'b1;
        @(negedge s_axi_aclk);

        for (int i = 0; i < n_init; i++) write_burst(4'(i), 32'(i * 64), 15, burst_incr, 1'b1);

        // INCR with random strobes, aliased upper bits and ignored low bits
        for (int i = 0; i < n_incr; i++) begin
            addr  = $random(seed);
            len   = rand_below(16);
            raddr = ($random(seed) & ~32'h7fc) | (addr & 32'h7fc);
            write_burst(4'(rand_below(16)), addr, len, burst_incr, 1'b0);
            read_burst(4'(rand_below(16)), raddr, len, burst_incr);
        end

        for (int i = 0; i < n_wrap; i++) begin
            addr = $random(seed);
            len  = (2 << (i % 4)) - 1;     // 2, 4, 8, 16 beats
            if (((addr >> 2) & 32'(len)) == 0) addr = addr + 32'd4;   // start off the block edge
            write_burst(4'(rand_below(16)), addr, len, `HBMC_BURST_WRAP, 1'b0);
            read_burst(4'(rand_below(16)), addr, len, `HBMC_BURST_WRAP);
        end

        // write to the lower half while reading the upper half
        for (int i = 0; i < n_pair; i++) begin
            addr  = 32'(rand_below(mem_bytes / 2 - 64));
            raddr = 32'(mem_bytes / 2 + rand_below(mem_bytes / 2 - 64));
            fork
                write_burst(4'(rand_below(16)), addr, rand_below(16), burst_incr, 1'b0);
                read_burst(4'(rand_below(16)), raddr, rand_below(16), burst_incr);
            join
        end

        repeat (4) @(negedge s_axi_aclk);
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+rtl
rtl/hbmc_pkg.sv
rtl/hbmc_stream_fifo.sv
rtl/hbmc_axi_arbiter.sv
rtl/hbmc_burst_engine.sv
rtl/hbmc_word_ram.sv
rtl/hbmc_axi_top.sv
tb/hbmc_assertions.sv
tb/hbmc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= hbmc_tb
FILELIST  ?= src.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
